// File: include/soc_bus_cfg.svh
`ifndef SOC_BUS_CFG_SVH
`define SOC_BUS_CFG_SVH

// bus widths, word addressed
`define SOC_ADDR_W 30
`define SOC_DATA_W 32
`define SOC_SEL_W 4

// region field of the word address, 8 MB per region
`define SOC_REGION_MSB 29
`define SOC_REGION_LSB 21

// region codes, sized to the region field
`define SOC_MEM_REGION 9'h000
`define SOC_INFO_REGION 9'h001

// switch/led port sits alone on one word
`define SOC_SWLED_ADDR 30'h0040_0001

// scratch memory index width in words
`define SOC_MEM_ADDR_W 10

// identification word of the simple device
`define SOC_INFO_ID 32'h2019_1028

`endif

// File: logic/bus_address_decoder.sv
`timescale 1ns/1ps
`include "soc_bus_cfg.svh"

module bus_address_decoder (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  soc_bus_pkg::bus_req_t   i_req,
    output soc_bus_pkg::bus_rsp_t   o_rsp,
    output logic                    o_mem_stb,
    output logic                    o_info_stb,
    output logic                    o_swled_stb,
    input  soc_bus_pkg::slave_rsp_t i_mem_rsp,
    input  soc_bus_pkg::slave_rsp_t i_info_rsp,
    input  soc_bus_pkg::slave_rsp_t i_swled_rsp,
    output logic                    o_bus_fault
);

    logic [`SOC_REGION_MSB:`SOC_REGION_LSB] region;
    logic                                   req_stb;
    logic                                   mem_sel;
    logic                                   info_sel;
    logic                                   swled_sel;
    logic                                   none_sel;
    logic                                   ack_q;
    logic                                   err_q;
    soc_bus_pkg::bus_data_t                 data_q;

    assign region  = i_req.addr[`SOC_REGION_MSB:`SOC_REGION_LSB];
    assign req_stb = i_req.cyc && i_req.stb;

    // address map
    assign mem_sel   = (region == `SOC_MEM_REGION);
    assign info_sel  = (region == `SOC_INFO_REGION);
    assign swled_sel = (i_req.addr == `SOC_SWLED_ADDR);
    assign none_sel  = !(mem_sel || info_sel || swled_sel);

    assign o_mem_stb   = req_stb && mem_sel;
    assign o_info_stb  = req_stb && info_sel;
    assign o_swled_stb = req_stb && swled_sel;

    // unmapped strobe, flagged in the cycle it is on the bus
    assign o_bus_fault = req_stb && none_sel;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            ack_q <= 1'b0;
            err_q <= 1'b0;
        end else begin
            ack_q <= i_info_rsp.ack || i_mem_rsp.ack || i_swled_rsp.ack;
            err_q <= o_bus_fault;
        end
    end

    // merged read data, info first, then memory, then switch/led
    always_ff @(posedge i_clk) begin
        if (i_info_rsp.ack) begin
            data_q <= i_info_rsp.data;
        end else if (i_mem_rsp.ack) begin
            data_q <= i_mem_rsp.data;
        end else if (i_swled_rsp.ack) begin
            data_q <= i_swled_rsp.data;
        end else begin
            data_q <= '0;
        end
    end

    // slaves never stall, stall to the masters comes from the arbiter
    assign o_rsp.ack   = ack_q;
    assign o_rsp.stall = 1'b0;
    assign o_rsp.err   = err_q;
    assign o_rsp.data  = data_q;

endmodule

// File: logic/bus_priority_arbiter.sv
`timescale 1ns/1ps

module bus_priority_arbiter (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  soc_bus_pkg::bus_req_t i_a_req,
    input  soc_bus_pkg::bus_req_t i_b_req,
    output soc_bus_pkg::bus_rsp_t o_a_rsp,
    output soc_bus_pkg::bus_rsp_t o_b_rsp,
    output soc_bus_pkg::bus_req_t o_req,
    input  soc_bus_pkg::bus_rsp_t i_rsp
);

    soc_bus_pkg::arb_owner_t owner_q;
    logic                    idle_q;
    soc_bus_pkg::arb_owner_t grant;
    logic                    grant_valid;
    logic                    owner_cyc;
    logic                    a_own;
    logic                    b_own;
    soc_bus_pkg::bus_req_t   sel_req;

    // response seen by one port, only the owner gets ack, err and data
    function automatic soc_bus_pkg::bus_rsp_t route_rsp(
        input logic                  own,
        input soc_bus_pkg::bus_rsp_t rsp
    );
        soc_bus_pkg::bus_rsp_t r;
        r.ack   = rsp.ack && own;
        r.err   = rsp.err && own;
        r.stall = !own || rsp.stall;
        r.data  = own ? rsp.data : '0;
        return r;
    endfunction

    assign owner_cyc = (owner_q == soc_bus_pkg::OWNER_A) ? i_a_req.cyc : i_b_req.cyc;

    // owner keeps the bus until it drops cyc, then A goes first
    always_comb begin
        if (!idle_q && owner_cyc) begin
            grant       = owner_q;
            grant_valid = 1'b1;
        end else if (i_a_req.cyc) begin
            grant       = soc_bus_pkg::OWNER_A;
            grant_valid = 1'b1;
        end else if (i_b_req.cyc) begin
            grant       = soc_bus_pkg::OWNER_B;
            grant_valid = 1'b1;
        end else begin
            grant       = owner_q;
            grant_valid = 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            owner_q <= soc_bus_pkg::OWNER_A;
            idle_q  <= 1'b1;
        end else begin
            owner_q <= grant;
            idle_q  <= !grant_valid;
        end
    end

    assign a_own = grant_valid && (grant == soc_bus_pkg::OWNER_A);
    assign b_own = grant_valid && (grant == soc_bus_pkg::OWNER_B);

    assign sel_req = b_own ? i_b_req : i_a_req;

    // request path stays combinational, no added latency
    always_comb begin
        o_req     = sel_req;
        o_req.cyc = sel_req.cyc && grant_valid;
        o_req.stb = sel_req.stb && grant_valid;
    end

    assign o_a_rsp = route_rsp(a_own, i_rsp);
    assign o_b_rsp = route_rsp(b_own, i_rsp);

endmodule

// File: logic/scratch_memory.sv
`timescale 1ns/1ps
`include "soc_bus_cfg.svh"

module scratch_memory (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  soc_bus_pkg::bus_req_t   i_req,
    input  logic                    i_stb,
    output soc_bus_pkg::slave_rsp_t o_rsp
);

    localparam int depth = 1 << `SOC_MEM_ADDR_W;

    soc_bus_pkg::bus_data_t      mem [depth];
    logic [`SOC_MEM_ADDR_W-1:0]  index;
    soc_bus_pkg::bus_data_t      rd_data;
    logic                        ack_q;

    // low address bits only, the rest of the region aliases
    assign index = i_req.addr[`SOC_MEM_ADDR_W-1:0];

    always_ff @(posedge i_clk) begin
        if (i_stb && i_req.we) begin
            for (int lane = 0; lane < `SOC_SEL_W; lane++) begin
                if (i_req.sel[lane]) begin
                    mem[index][lane*8 +: 8] <= i_req.data[lane*8 +: 8];
                end
            end
        end
        // old contents on a write strobe
        if (i_stb) begin
            rd_data <= mem[index];
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= i_stb;
        end
    end

    assign o_rsp.ack  = ack_q;
    assign o_rsp.data = rd_data;

endmodule

// File: logic/soc_bus_pkg.sv
`include "soc_bus_cfg.svh"

package soc_bus_pkg;

    // word address, data word and byte lanes
    typedef logic [`SOC_ADDR_W-1:0] bus_addr_t;
    typedef logic [`SOC_DATA_W-1:0] bus_data_t;
    typedef logic [`SOC_SEL_W-1:0]  bus_sel_t;

    // request from a master, or the merged one from the arbiter
    typedef struct packed {
        logic      cyc;
        logic      stb;
        logic      we;
        bus_addr_t addr;
        bus_data_t data;
        bus_sel_t  sel;
    } bus_req_t;

    // response back to a master
    typedef struct packed {
        logic      ack;
        logic      stall;
        logic      err;
        bus_data_t data;
    } bus_rsp_t;

    // response of one slave, none of them stall
    typedef struct packed {
        logic      ack;
        bus_data_t data;
    } slave_rsp_t;

    // which master port holds the bus
    typedef enum logic {
        OWNER_A,
        OWNER_B
    } arb_owner_t;

endpackage

// File: logic/soc_bus_top.sv
`timescale 1ns/1ps

module soc_bus_top (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  soc_bus_pkg::bus_req_t i_a_req,
    input  soc_bus_pkg::bus_req_t i_b_req,
    output soc_bus_pkg::bus_rsp_t o_a_rsp,
    output soc_bus_pkg::bus_rsp_t o_b_rsp,
    input  logic [15:0]           i_switches,
    output logic [15:0]           o_leds,
    output logic                  o_interrupt
);

    // merged bus between arbiter and decoder
    soc_bus_pkg::bus_req_t   bus_req;
    soc_bus_pkg::bus_rsp_t   bus_rsp;

    logic                    mem_stb;
    logic                    info_stb;
    logic                    swled_stb;
    logic                    bus_fault;
    soc_bus_pkg::slave_rsp_t mem_rsp;
    soc_bus_pkg::slave_rsp_t info_rsp;
    soc_bus_pkg::slave_rsp_t swled_rsp;

    // port A has priority over port B
    bus_priority_arbiter arbiter_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_a_req (i_a_req),
        .i_b_req (i_b_req),
        .o_a_rsp (o_a_rsp),
        .o_b_rsp (o_b_rsp),
        .o_req   (bus_req),
        .i_rsp   (bus_rsp)
    );

    bus_address_decoder decoder_i (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_req       (bus_req),
        .o_rsp       (bus_rsp),
        .o_mem_stb   (mem_stb),
        .o_info_stb  (info_stb),
        .o_swled_stb (swled_stb),
        .i_mem_rsp   (mem_rsp),
        .i_info_rsp  (info_rsp),
        .i_swled_rsp (swled_rsp),
        .o_bus_fault (bus_fault)
    );

    system_info_regs info_i (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_req       (bus_req),
        .i_stb       (info_stb),
        .i_bus_fault (bus_fault),
        .o_rsp       (info_rsp),
        .o_interrupt (o_interrupt)
    );

    scratch_memory mem_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_req   (bus_req),
        .i_stb   (mem_stb),
        .o_rsp   (mem_rsp)
    );

    switch_led_port swled_i (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_req      (bus_req),
        .i_stb      (swled_stb),
        .o_rsp      (swled_rsp),
        .i_switches (i_switches),
        .o_leds     (o_leds)
    );

endmodule

// File: logic/switch_led_port.sv
`timescale 1ns/1ps

module switch_led_port (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  soc_bus_pkg::bus_req_t   i_req,
    input  logic                    i_stb,
    output soc_bus_pkg::slave_rsp_t o_rsp,
    input  logic [15:0]             i_switches,
    output logic [15:0]             o_leds
);

    logic [15:0]            sw_meta;
    logic [15:0]            sw_sync;
    logic [15:0]            leds_q;
    logic                   ack_q;
    soc_bus_pkg::bus_data_t rd_data;

    // two-flop synchroniser, switches are asynchronous
    always_ff @(posedge i_clk) begin
        sw_meta <= i_switches;
        sw_sync <= sw_meta;
        if (i_stb) begin
            rd_data <= {leds_q, sw_sync};
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            leds_q <= '0;
            ack_q  <= 1'b0;
        end else begin
            ack_q <= i_stb;
            if (i_stb && i_req.we) begin
                leds_q <= i_req.data[15:0];
            end
        end
    end

    assign o_rsp.ack  = ack_q;
    assign o_rsp.data = rd_data;
    assign o_leds     = leds_q;

endmodule

// File: logic/system_info_regs.sv
`timescale 1ns/1ps
`include "soc_bus_cfg.svh"

module system_info_regs (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  soc_bus_pkg::bus_req_t   i_req,
    input  logic                    i_stb,
    input  logic                    i_bus_fault,
    output soc_bus_pkg::slave_rsp_t o_rsp,
    output logic                    o_interrupt
);

    logic [3:0]                offset;
    logic                      ack_q;
    logic                      irq_q;
    soc_bus_pkg::bus_data_t    rd_data;
    soc_bus_pkg::bus_data_t    scratch;
    soc_bus_pkg::bus_data_t    power_cnt;
    soc_bus_pkg::bus_data_t    power_next;
    soc_bus_pkg::bus_addr_t    fault_addr;

    assign offset = i_req.addr[3:0];

    // control state: ack, interrupt bit, power counter
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            ack_q     <= 1'b0;
            irq_q     <= 1'b0;
            power_cnt <= '0;
        end else begin
            ack_q     <= i_stb;
            power_cnt <= {power_cnt[31] | power_next[31], power_next[30:0]};
            if (i_stb && i_req.we && (offset == 4'h4)) begin
                irq_q <= i_req.data[0];
            end
        end
    end

    // bit 31 sticks once reached
    assign power_next = power_cnt + 1'b1;

    always_ff @(posedge i_clk) begin
        if (i_stb && i_req.we && (offset == 4'h1)) begin
            scratch <= i_req.data;
        end
        // address of the unmapped strobe on the bus right now
        if (i_bus_fault) begin
            fault_addr <= i_req.addr;
        end
        if (i_stb) begin
            case (offset)
                4'h0:    rd_data <= `SOC_INFO_ID;
                4'h1:    rd_data <= scratch;
                4'h2:    rd_data <= {fault_addr, 2'b00};
                4'h3:    rd_data <= power_cnt;
                4'h4:    rd_data <= {31'h0, irq_q};
                default: rd_data <= '0;
            endcase
        end
    end

    assign o_rsp.ack   = ack_q;
    assign o_rsp.data  = rd_data;
    assign o_interrupt = irq_q;

endmodule

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and search the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module soc_bus_tb -f sources.f -o soc_bus_sim \
    && ./obj_dir/soc_bus_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Everything OK" sim.log 2>/dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: sources.f
+incdir+include
logic/soc_bus_pkg.sv
logic/bus_priority_arbiter.sv
logic/bus_address_decoder.sv
logic/system_info_regs.sv
logic/scratch_memory.sv
logic/switch_led_port.sv
logic/soc_bus_top.sv
verification/soc_bus_props.sv
verification/soc_bus_tb.sv

// File: verification/soc_bus_props.sv
`timescale 1ns/1ps

module soc_bus_props (
    input logic                  i_clk,
    input logic                  i_rst_n,
    input soc_bus_pkg::bus_req_t i_a_req,
    input soc_bus_pkg::bus_req_t i_b_req,
    input soc_bus_pkg::bus_rsp_t i_a_rsp,
    input soc_bus_pkg::bus_rsp_t i_b_rsp
);

    logic a_take;
    logic b_take;

    // strobe accepted on a master port
    assign a_take = i_a_req.cyc && i_a_req.stb && !i_a_rsp.stall;
    assign b_take = i_b_req.cyc && i_b_req.stb && !i_b_rsp.stall;

    a_ack_err_apart: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_a_rsp.ack && i_a_rsp.err))
        else $error("port A shows ack and err in the same cycle");

    b_ack_err_apart: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_b_rsp.ack && i_b_rsp.err))
        else $error("port B shows ack and err in the same cycle");

    // err one cycle after acceptance, otherwise ack one cycle later
    a_answered: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $past(a_take, 2) && !$past(i_a_rsp.err) |-> i_a_rsp.ack)
        else $error("port A strobe got neither err nor ack in time");

    b_answered: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $past(b_take, 2) && !$past(i_b_rsp.err) |-> i_b_rsp.ack)
        else $error("port B strobe got neither err nor ack in time");

    // a port holding the bus keeps it while cyc stays high
    a_owner_no_stall: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_a_req.cyc && !i_a_rsp.stall |=> !i_a_req.cyc || !i_a_rsp.stall)
        else $error("port A stalled while it owns the bus");

    b_owner_no_stall: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_b_req.cyc && !i_b_rsp.stall |=> !i_b_req.cyc || !i_b_rsp.stall)
        else $error("port B stalled while it owns the bus");

    ack_in_reset: assert property (@(posedge i_clk)
        !i_rst_n && $past(!i_rst_n) |-> !i_a_rsp.ack && !i_b_rsp.ack)
        else $error("ack raised during reset");

endmodule

// File: verification/soc_bus_tb.sv
`timescale 1ns/1ps

module soc_bus_tb;

    localparam int wait_limit = 40;
    localparam soc_bus_pkg::bus_addr_t info_base  = 30'h0020_0000;
    localparam soc_bus_pkg::bus_addr_t swled_addr = 30'h0040_0001;
    localparam soc_bus_pkg::bus_addr_t bad_addr   = 30'h0040_0005;

    logic                  clk;
    logic                  rst_n;
    soc_bus_pkg::bus_req_t a_req;
    soc_bus_pkg::bus_req_t b_req;
    soc_bus_pkg::bus_rsp_t a_rsp;
    soc_bus_pkg::bus_rsp_t b_rsp;
    logic [15:0]           switches;
    logic [15:0]           leds;
    logic                  interrupt;
    int                    seed = 85;
    int                    errors = 0;
    int                    timeouts = 0;

    soc_bus_top dut_i (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_a_req     (a_req),
        .i_b_req     (b_req),
        .o_a_rsp     (a_rsp),
        .o_b_rsp     (b_rsp),
        .i_switches  (switches),
        .o_leds      (leds),
        .o_interrupt (interrupt)
    );

    bind soc_bus_top soc_bus_props props_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_a_req (i_a_req),
        .i_b_req (i_b_req),
        .i_a_rsp (o_a_rsp),
        .i_b_rsp (o_b_rsp)
    );

    always #10 clk = ~clk;

    task automatic check_value(input string name, input soc_bus_pkg::bus_data_t got,
                               input soc_bus_pkg::bus_data_t exp);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_at_least(input string name, input int got, input int low);
        assert (got >= low) else begin
            $display("CHECK FAILED at %0t: %s got %0d expected at least %0d",
                     $time, name, got, low);
            errors++;
        end
    endtask

    task automatic drive_port(input logic on_b, input soc_bus_pkg::bus_req_t req);
        if (on_b) begin
            b_req = req;
        end else begin
            a_req = req;
        end
    endtask

    function automatic soc_bus_pkg::bus_rsp_t port_rsp(input logic on_b);
        return on_b ? b_rsp : a_rsp;
    endfunction

    // one strobe on a master port, cyc held until the answer
    task automatic bus_access(
        input  logic                   on_b,
        input  logic                   we,
        input  soc_bus_pkg::bus_addr_t addr,
        input  soc_bus_pkg::bus_data_t wdata,
        input  soc_bus_pkg::bus_sel_t  sel,
        output soc_bus_pkg::bus_data_t rdata,
        output logic                   got_ack,
        output logic                   got_err,
        output int                     stalls
    );
        soc_bus_pkg::bus_req_t req;
        soc_bus_pkg::bus_rsp_t rsp;
        int                    waited;
        req.cyc  = 1'b1;
        req.stb  = 1'b1;
        req.we   = we;
        req.addr = addr;
        req.data = wdata;
        req.sel  = sel;
        stalls   = 0;
        waited   = 0;
        @(negedge clk);
        drive_port(on_b, req);
        #1;
        rsp = port_rsp(on_b);
        while (rsp.stall && stalls < wait_limit) begin
            @(negedge clk);
            #1;
            stalls++;
            rsp = port_rsp(on_b);
        end
        if (rsp.stall) begin
            $display("timeout at %0t: port %s never got the bus", $time, on_b ? "B" : "A");
            timeouts++;
        end
        // strobe taken at the rising edge just passed
        @(negedge clk);
        req.stb = 1'b0;
        drive_port(on_b, req);
        #1;
        rsp = port_rsp(on_b);
        while (!rsp.ack && !rsp.err && waited < wait_limit) begin
            @(negedge clk);
            #1;
            waited++;
            rsp = port_rsp(on_b);
        end
        if (!rsp.ack && !rsp.err) begin
            $display("timeout at %0t: port %s got neither ack nor err", $time,
                     on_b ? "B" : "A");
            timeouts++;
        end
        rdata   = rsp.data;
        got_ack = rsp.ack;
        got_err = rsp.err;
        @(negedge clk);
        req.cyc = 1'b0;
        req.we  = 1'b0;
        drive_port(on_b, req);
    endtask

    task automatic write_word(input logic on_b, input soc_bus_pkg::bus_addr_t addr,
                              input soc_bus_pkg::bus_data_t data,
                              input soc_bus_pkg::bus_sel_t sel);
        soc_bus_pkg::bus_data_t rdata;
        logic                   ack;
        logic                   err;
        int                     stalls;
        bus_access(on_b, 1'b1, addr, data, sel, rdata, ack, err, stalls);
        check_value("write ack", {31'h0, ack}, 32'h1);
    endtask

    task automatic read_word(input logic on_b, input soc_bus_pkg::bus_addr_t addr,
                             output soc_bus_pkg::bus_data_t data);
        logic ack;
        logic err;
        int   stalls;
        bus_access(on_b, 1'b0, addr, '0, 4'hF, data, ack, err, stalls);
        check_value("read ack", {31'h0, ack}, 32'h1);
    endtask

    initial begin
        soc_bus_pkg::bus_addr_t mem_addr [4];
        soc_bus_pkg::bus_data_t mem_data [4];
        soc_bus_pkg::bus_addr_t base;
        soc_bus_pkg::bus_data_t wdata;
        soc_bus_pkg::bus_data_t rdata;
        soc_bus_pkg::bus_data_t a_data;
        soc_bus_pkg::bus_data_t b_data;
        soc_bus_pkg::bus_data_t count0;
        logic                   got_ack;
        logic                   got_err;
        int                     a_stalls;
        int                     b_stalls;
        time                    a_done;
        time                    b_done;
        clk      = 1'b0;
        rst_n    = 1'b0;
        a_req    = '0;
        b_req    = '0;
        switches = 16'h0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_value("o_leds", {16'h0, leds}, 32'h0);
        check_value("o_interrupt", {31'h0, interrupt}, 32'h0);

        // scratch memory, full words then one byte lane then an alias
        base = soc_bus_pkg::bus_addr_t'($random(seed)) & 30'h3F8;
        for (int i = 0; i < 4; i++) begin
            mem_addr[i] = base + i;
            mem_data[i] = $random(seed);
            write_word(1'b0, mem_addr[i], mem_data[i], 4'hF);
        end
        for (int i = 0; i < 4; i++) begin
            read_word(1'b0, mem_addr[i], rdata);
            check_value("memory word", rdata, mem_data[i]);
        end
        wdata = $random(seed);
        write_word(1'b0, mem_addr[0], wdata, 4'b0100);
        mem_data[0] = (mem_data[0] & 32'hFF00_FFFF) | (wdata & 32'h00FF_0000);
        read_word(1'b0, mem_addr[0], rdata);
        check_value("memory byte lane 2", rdata, mem_data[0]);
        mem_data[1] = $random(seed);
        write_word(1'b0, mem_addr[1] + 30'd1024, mem_data[1], 4'hF);
        read_word(1'b0, mem_addr[1], rdata);
        check_value("memory alias", rdata, mem_data[1]);

        // system info registers
        read_word(1'b0, info_base, rdata);
        check_value("info id", rdata, 32'h2019_1028);
        wdata = $random(seed);
        write_word(1'b0, info_base + 30'd1, wdata, 4'hF);
        read_word(1'b0, info_base + 30'd1, rdata);
        check_value("info scratch", rdata, wdata);
        write_word(1'b0, info_base + 30'd4, 32'h1, 4'hF);
        check_value("o_interrupt", {31'h0, interrupt}, 32'h1);
        read_word(1'b0, info_base + 30'd4, rdata);
        check_value("info interrupt", rdata, 32'h1);
        write_word(1'b0, info_base + 30'd4, 32'h0, 4'hF);
        check_value("o_interrupt", {31'h0, interrupt}, 32'h0);
        read_word(1'b0, info_base + 30'd4, rdata);
        check_value("info interrupt", rdata, 32'h0);

        // unmapped word gives err, and its byte address is kept
        bus_access(1'b0, 1'b0, bad_addr, '0, 4'hF, rdata, got_ack, got_err, a_stalls);
        check_value("unmapped err", {31'h0, got_err}, 32'h1);
        check_value("unmapped ack", {31'h0, got_ack}, 32'h0);
        check_value("unmapped data", rdata, 32'h0);
        read_word(1'b0, info_base + 30'd2, rdata);
        check_value("fault address", rdata, 32'(bad_addr) * 32'd4);
        bus_access(1'b1, 1'b0, bad_addr + 30'd1, '0, 4'hF, rdata, got_ack, got_err,
                   b_stalls);
        check_value("port B unmapped err", {31'h0, got_err}, 32'h1);
        check_value("port B unmapped ack", {31'h0, got_ack}, 32'h0);

        // both ports start together, A first
        fork
            begin
                bus_access(1'b0, 1'b0, mem_addr[2], '0, 4'hF, a_data, got_ack, got_err,
                           a_stalls);
                a_done = $time;
            end
            begin
                bus_access(1'b1, 1'b0, mem_addr[3], '0, 4'hF, b_data, got_ack, got_err,
                           b_stalls);
                b_done = $time;
            end
        join
        check_value("port A read", a_data, mem_data[2]);
        check_value("port B read", b_data, mem_data[3]);
        check_value("port A stall cycles", a_stalls, 32'd0);
        check_at_least("port B stall cycles", b_stalls, 1);
        check_at_least("port B finish after port A", int'(b_done - a_done), 1);

        // port B holds the bus while port A asks for it
        fork
            begin
                bus_access(1'b1, 1'b0, mem_addr[0], '0, 4'hF, b_data, got_ack, got_err,
                           b_stalls);
                b_done = $time;
            end
            begin
                @(negedge clk);
                bus_access(1'b0, 1'b0, mem_addr[1], '0, 4'hF, a_data, got_ack, got_err,
                           a_stalls);
                a_done = $time;
            end
        join
        check_value("port B read", b_data, mem_data[0]);
        check_value("port A read", a_data, mem_data[1]);
        check_value("port B stall cycles", b_stalls, 32'd0);
        check_at_least("port A stall cycles", a_stalls, 1);
        check_at_least("port A finish after port B", int'(a_done - b_done), 1);

        // switches held steady across the synchroniser
        @(negedge clk);
        switches = 16'($random(seed));
        wdata = $random(seed);
        write_word(1'b0, swled_addr, wdata, 4'hF);
        check_value("o_leds", {16'h0, leds}, {16'h0, wdata[15:0]});
        read_word(1'b1, swled_addr, rdata);
        check_value("switch/led read", rdata, {wdata[15:0], switches});

        // power counter keeps running between reads
        read_word(1'b0, info_base + 30'd3, count0);
        repeat (20) @(negedge clk);
        read_word(1'b0, info_base + 30'd3, rdata);
        check_at_least("power counter step", int'(rdata - count0), 20);

        $display("value errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
